// File: capture_fsm.sv
`timescale 1ns/100ps

module capture_fsm (
  input  logic                       clk,
  input  logic                       uart_reset,
  input  logic                       store,
  input  logic                       send,
  input  logic                       frame_full,
  input  logic                       frame_sent,
  output frame_uart_pkg::fsm_state_t state
);

  frame_uart_pkg::fsm_state_t state_next;

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      frame_uart_pkg::ST_IDLE: begin
        // store switch opens a capture
        if (store) begin
          state_next = frame_uart_pkg::ST_SAVE;
        end
      end
      frame_uart_pkg::ST_SAVE: begin
        // last pixel written
        if (frame_full) begin
          state_next = frame_uart_pkg::ST_HOLD;
        end
      end
      frame_uart_pkg::ST_HOLD: begin
        // frame parked until the pc asks for it
        if (send) begin
          state_next = frame_uart_pkg::ST_SEND;
        end
      end
      frame_uart_pkg::ST_SEND: begin
        // stop bit of the final byte is out
        if (frame_sent) begin
          state_next = frame_uart_pkg::ST_IDLE;
        end
      end
      default: begin
        state_next = frame_uart_pkg::ST_IDLE;
      end
    endcase
  end

  // state register
  always_ff @(posedge clk) begin
    if (uart_reset) begin
      state <= frame_uart_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // done strobe from the serializer must only show up while sending
  a_sent_only_in_send: assert property (@(posedge clk) disable iff (uart_reset)
    frame_sent |-> state == frame_uart_pkg::ST_SEND);

endmodule

// File: frame_store.sv
`timescale 1ns/100ps

module frame_store #(
  parameter int FRAME_PIXELS = 16
) (
  input  logic                              clk,
  input  logic                              uart_reset,
  input  frame_uart_pkg::fsm_state_t        state,
  input  frame_uart_pkg::pixel_t            pixel_in,
  input  logic                              pixel_valid,
  input  logic [$clog2(FRAME_PIXELS)-1:0]   rd_addr,
  output frame_uart_pkg::pixel_t            rd_pixel,
  output logic                              frame_full
);

  localparam int ADDR_W = $clog2(FRAME_PIXELS);
  // one extra bit so the counter can sit at FRAME_PIXELS
  localparam int CNT_W  = $clog2(FRAME_PIXELS + 1);

  frame_uart_pkg::pixel_t mem [FRAME_PIXELS];

  logic [CNT_W-1:0]  wr_count;
  logic [ADDR_W-1:0] wr_addr;
  logic              wr_en;

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  // strobes outside the save state are dropped
  assign wr_en   = pixel_valid && (state == frame_uart_pkg::ST_SAVE);
  assign wr_addr = wr_count[ADDR_W-1:0];

  // high in the cycle of the last write
  assign frame_full = wr_en && (wr_count == CNT_W'(FRAME_PIXELS - 1));

  // address counter, back to 0 whenever we are not saving
  always_ff @(posedge clk) begin
    if (uart_reset || (state != frame_uart_pkg::ST_SAVE)) begin
      wr_count <= '0;
    end else if (wr_en) begin
      wr_count <= wr_count + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory array
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= pixel_in;
    end
    // read data one clock behind the address
    rd_pixel <= mem[rd_addr];
  end

  // controller has to leave save before another strobe lands
  a_no_write_past_full: assert property (@(posedge clk) disable iff (uart_reset)
    wr_en |-> wr_count < CNT_W'(FRAME_PIXELS));

endmodule

// File: frame_uart_pkg.sv
package frame_uart_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // pixel format
  ////////////////////////////////////////////////////////////////////////////

  // rgb332, red in the top bits like the old bram word
  typedef struct packed {
    logic [2:0] red;
    logic [2:0] green;
    logic [1:0] blue;
  } pixel_t;

  ////////////////////////////////////////////////////////////////////////////
  // control encodings
  ////////////////////////////////////////////////////////////////////////////

  // main controller, cut down to capture and transfer
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_SAVE = 2'd1,
    ST_HOLD = 2'd2,
    ST_SEND = 2'd3
  } fsm_state_t;

  // byte order per pixel on the serial line
  // green goes first, red last
  typedef enum logic [1:0] {
    CH_GREEN = 2'd0,
    CH_BLUE  = 2'd1,
    CH_RED   = 2'd2
  } tx_channel_t;

  ////////////////////////////////////////////////////////////////////////////
  // defaults for the top level
  ////////////////////////////////////////////////////////////////////////////

  // pixels per stored frame
  localparam int DEFAULT_FRAME_PIXELS = 16;
  // clocks per uart bit time
  localparam int DEFAULT_CLKS_PER_BIT = 8;

endpackage

// File: frame_uart_tests.txt
# columns: test name, early send flag, then 8 rgb332 pixels in hex, pixel 0 first
# early send flag 1 pulses send in idle before the store, which must be ignored
# each frame overwrites the one before it
first_frame 0 e3 1c 03 ff 00 92 6d 49
second_frame 1 25 b6 db 7f 80 44 11 a5
ramp_frame 0 01 02 04 08 10 20 40 80
mixed_frame 1 fe fd fb f7 ef df bf 7e

// File: frame_uart_top.sv
`timescale 1ns/100ps

module frame_uart_top #(
  parameter int FRAME_PIXELS = frame_uart_pkg::DEFAULT_FRAME_PIXELS,
  parameter int CLKS_PER_BIT = frame_uart_pkg::DEFAULT_CLKS_PER_BIT
) (
  input  logic                       clk,
  input  logic                       uart_reset,
  input  logic                       store,
  input  logic                       send,
  input  frame_uart_pkg::pixel_t     pixel_in,
  input  logic                       pixel_valid,
  output logic                       txd,
  output frame_uart_pkg::fsm_state_t state
);

  localparam int ADDR_W = $clog2(FRAME_PIXELS);

  // controller events
  logic frame_full;
  logic frame_sent;

  // memory read port
  logic [ADDR_W-1:0]      rd_addr;
  frame_uart_pkg::pixel_t rd_pixel;

  // serializer to transmitter
  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_accept;
  logic       tx_busy;

  // transmitter also held clear while idle
  wire tx_clear = uart_reset || (state == frame_uart_pkg::ST_IDLE);

  ////////////////////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////////////////////

  capture_fsm u_fsm (
    .clk        (clk),
    .uart_reset (uart_reset),
    .store      (store),
    .send       (send),
    .frame_full (frame_full),
    .frame_sent (frame_sent),
    .state      (state)
  );

  frame_store #(.FRAME_PIXELS(FRAME_PIXELS)) u_store (
    .clk         (clk),
    .uart_reset  (uart_reset),
    .state       (state),
    .pixel_in    (pixel_in),
    .pixel_valid (pixel_valid),
    .rd_addr     (rd_addr),
    .rd_pixel    (rd_pixel),
    .frame_full  (frame_full)
  );

  pixel_serializer #(.FRAME_PIXELS(FRAME_PIXELS)) u_ser (
    .clk        (clk),
    .uart_reset (uart_reset),
    .state      (state),
    .rd_pixel   (rd_pixel),
    .tx_accept  (tx_accept),
    .tx_busy    (tx_busy),
    .rd_addr    (rd_addr),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte),
    .frame_sent (frame_sent)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
    .clk        (clk),
    .uart_reset (tx_clear),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte),
    .txd        (txd),
    .tx_busy    (tx_busy),
    .tx_accept  (tx_accept)
  );

endmodule

// File: pixel_serializer.sv
`timescale 1ns/100ps

module pixel_serializer #(
  parameter int FRAME_PIXELS = 16
) (
  input  logic                              clk,
  input  logic                              uart_reset,
  input  frame_uart_pkg::fsm_state_t        state,
  input  frame_uart_pkg::pixel_t            rd_pixel,
  input  logic                              tx_accept,
  input  logic                              tx_busy,
  output logic [$clog2(FRAME_PIXELS)-1:0]   rd_addr,
  output logic                              tx_start,
  output logic [7:0]                        tx_byte,
  output logic                              frame_sent
);

  localparam int ADDR_W = $clog2(FRAME_PIXELS);
  localparam int CNT_W  = $clog2(FRAME_PIXELS + 1);

  frame_uart_pkg::tx_channel_t channel;

  logic [CNT_W-1:0] pix_count;
  logic             rd_ready;
  logic             all_sent;
  logic             busy_q;
  logic             sending;

  assign sending  = (state == frame_uart_pkg::ST_SEND);
  assign all_sent = (pix_count == CNT_W'(FRAME_PIXELS));

  // park on 0 once the count runs past the array
  assign rd_addr = all_sent ? '0 : pix_count[ADDR_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // channel and pixel sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset || !sending) begin
      channel   <= frame_uart_pkg::CH_GREEN;
      pix_count <= '0;
      rd_ready  <= 1'b0;
    end else if (tx_accept) begin
      case (channel)
        frame_uart_pkg::CH_GREEN: channel <= frame_uart_pkg::CH_BLUE;
        frame_uart_pkg::CH_BLUE:  channel <= frame_uart_pkg::CH_RED;
        default: begin
          // red done, step to the next pixel
          channel   <= frame_uart_pkg::CH_GREEN;
          pix_count <= pix_count + 1'b1;
          // new address, memory output is stale for a clock
          rd_ready  <= 1'b0;
        end
      endcase
    end else begin
      rd_ready <= 1'b1;
    end
  end

  // held until the transmitter takes it
  assign tx_start = sending && rd_ready && !all_sent;

  // channel left-aligned, low bits zero
  always_comb begin
    case (channel)
      frame_uart_pkg::CH_GREEN: tx_byte = {rd_pixel.green, 5'd0};
      frame_uart_pkg::CH_BLUE:  tx_byte = {rd_pixel.blue, 6'd0};
      frame_uart_pkg::CH_RED:   tx_byte = {rd_pixel.red, 5'd0};
      default:                  tx_byte = 8'd0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // end of frame
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= tx_busy;
    end
  end

  // falling busy after the last accept means the last stop bit is out
  assign frame_sent = sending && all_sent && busy_q && !tx_busy;

  a_channel_legal: assert property (@(posedge clk) disable iff (uart_reset)
    channel inside {frame_uart_pkg::CH_GREEN, frame_uart_pkg::CH_BLUE,
                    frame_uart_pkg::CH_RED});

endmodule

// File: project.f
frame_uart_pkg.sv
capture_fsm.sv
frame_store.sv
pixel_serializer.sv
uart_tx.sv
frame_uart_top.sv
tb_frame_uart.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_frame_uart -f project.f
sim_out=$(./obj_dir/Vtb_frame_uart)
echo "$sim_out"
if echo "$sim_out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

// File: tb_frame_uart.sv
`timescale 1ns/100ps

module tb_frame_uart;

  localparam int FRAME_PIXELS = 8;
  localparam int CLKS_PER_BIT = 8;

  logic                       clk;
  logic                       uart_reset;
  logic                       store;
  logic                       send;
  frame_uart_pkg::pixel_t     pixel_in;
  logic                       pixel_valid;
  logic                       txd;
  frame_uart_pkg::fsm_state_t state;

  // current frame from the data file, pixel 0 first
  logic [7:0] frame_pix [FRAME_PIXELS];

  int errors;
  int tests_run;
  int tests_failed;

  // raised once a wait gives up
  event abort_ev;

  frame_uart_top #(.FRAME_PIXELS(FRAME_PIXELS), .CLKS_PER_BIT(CLKS_PER_BIT)) u_dut (
    .clk         (clk),
    .uart_reset  (uart_reset),
    .store       (store),
    .send        (send),
    .pixel_in    (pixel_in),
    .pixel_valid (pixel_valid),
    .txd         (txd),
    .state       (state)
  );

  // 20 ns period
  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // one clock, then settle 2 ns past the edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  // report and park this process until the watcher ends the run
  task automatic abort_run(input string why);
    $display("ERROR: %s at time %0t", why, $time);
    -> abort_ev;
    forever @(posedge clk);
  endtask

  task automatic check_value(input int got, input int exp, input string what);
    assert (got == exp) else begin
      errors++;
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // rgb332 in the byte: red [7:5], green [4:2], blue [1:0]
  // order on the line is green, blue, red, each left-aligned
  function automatic int expected_byte(input logic [7:0] pix, input int channel);
    if (channel == 0) begin
      return {pix[4:2], 5'b0};
    end else if (channel == 1) begin
      return {pix[1:0], 6'b0};
    end
    return {pix[7:5], 5'b0};
  endfunction

  // fixed-length watch of the quiet idle line
  task automatic watch_idle(input int cycles);
    repeat (cycles) begin
      step();
      check_value(int'(state), int'(frame_uart_pkg::ST_IDLE), "idle state");
      check_value(txd, 1, "idle txd");
    end
  endtask

  task automatic wait_for_state(input frame_uart_pkg::fsm_state_t target, input int limit);
    int n;
    n = 0;
    while (state != target && n < limit) begin
      step();
      n++;
    end
    if (state != target) begin
      abort_run($sformatf("timed out waiting for state %s", target.name()));
    end
  endtask

  task automatic drive_strobe(input logic [7:0] pix);
    pixel_in    = pix;
    pixel_valid = 1'b1;
    step();
    pixel_valid = 1'b0;
  endtask

  // 8n1 decode, sampled mid-bit
  task automatic receive_byte(output logic [7:0] data);
    int n;
    int i;
    n = 0;
    while (txd !== 1'b0 && n < 40 * CLKS_PER_BIT) begin
      step();
      n++;
    end
    if (txd !== 1'b0) begin
      abort_run("no start bit seen on txd");
    end
    repeat (CLKS_PER_BIT / 2) step();
    check_value(txd, 0, "start bit");
    for (i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) step();
      data[i] = txd;
    end
    repeat (CLKS_PER_BIT) step();
    check_value(txd, 1, "stop bit");
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors > errors_before) begin
      tests_failed++;
      $display("test %s: FAIL, %0d errors", name, errors - errors_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one frame: capture, hold, send, decode
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_frame_test(input string name, input int early_send);
    int err0;
    int i;
    int ch;
    logic [7:0] rx;
    err0 = errors;
    // send before any frame is stored goes nowhere
    if (early_send != 0) begin
      send = 1'b1;
      step();
      send = 1'b0;
      watch_idle(20);
    end
    // strobes in idle must not land in memory
    drive_strobe(~frame_pix[0]);
    drive_strobe(~frame_pix[1]);
    store = 1'b1;
    wait_for_state(frame_uart_pkg::ST_SAVE, 10);
    store = 1'b0;
    for (i = 0; i < FRAME_PIXELS; i++) begin
      repeat ($urandom % 4) step();
      check_value(int'(state), int'(frame_uart_pkg::ST_SAVE), "state before write");
      drive_strobe(frame_pix[i]);
    end
    wait_for_state(frame_uart_pkg::ST_HOLD, 4);
    // a strobe while holding must leave pixel 0 alone
    drive_strobe(~frame_pix[0]);
    send = 1'b1;
    step();
    send = 1'b0;
    for (i = 0; i < FRAME_PIXELS; i++) begin
      for (ch = 0; ch < 3; ch++) begin
        receive_byte(rx);
        check_value(rx, expected_byte(frame_pix[i], ch),
                    $sformatf("pixel %0d channel %0d", i, ch));
      end
    end
    // back to idle within the rest of the last stop bit
    wait_for_state(frame_uart_pkg::ST_IDLE, CLKS_PER_BIT);
    check_value(txd, 1, "txd after frame");
    finish_test(name, err0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // run end on a timeout
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    @(abort_ev);
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int fd;
    int count;
    int early;
    int err0;
    string line;
    string name;
    clk         = 1'b0;
    uart_reset  = 1'b1;
    store       = 1'b0;
    send        = 1'b0;
    pixel_in    = '0;
    pixel_valid = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(96));
    repeat (2) step();
    uart_reset = 1'b0;

    err0 = errors;
    watch_idle(50);
    finish_test("reset_idle", err0);

    err0 = errors;
    send = 1'b1;
    step();
    send = 1'b0;
    watch_idle(200);
    finish_test("idle_send_ignored", err0);

    fd = $fopen("frame_uart_tests.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open frame_uart_tests.txt");
    end
    while (!$feof(fd)) begin
      line  = "";
      count = $fgets(line, fd);
      // skip comments and blank lines
      if (line.len() > 1 && line.getc(0) != "#") begin
        count = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", name, early,
                        frame_pix[0], frame_pix[1], frame_pix[2], frame_pix[3],
                        frame_pix[4], frame_pix[5], frame_pix[6], frame_pix[7]);
        if (count != 10) begin
          abort_run($sformatf("bad line in test file: %s", line));
        end
        run_frame_test(name, early);
      end
    end
    $fclose(fd);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: uart_tx.sv
`timescale 1ns/100ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic       clk,
  input  logic       uart_reset,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       txd,
  output logic       tx_busy,
  output logic       tx_accept
);

  localparam int BAUD_W = $clog2(CLKS_PER_BIT);

  logic [BAUD_W-1:0] baud_count;
  logic [3:0]        bit_index;
  // stop, data, start; bit 0 is on the line
  logic [9:0]        shift_q;
  logic              bit_end;

  ////////////////////////////////////////////////////////////////////////////
  // handshake and line
  ////////////////////////////////////////////////////////////////////////////

  // byte taken only while idle
  assign tx_accept = tx_start && !tx_busy;

  // last clock of the current bit time
  assign bit_end = (baud_count == BAUD_W'(CLKS_PER_BIT - 1));

  // ones shift in behind the frame so the line rests high
  assign txd = shift_q[0];

  ////////////////////////////////////////////////////////////////////////////
  // 8n1 frame engine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      shift_q    <= '1;
      tx_busy    <= 1'b0;
      baud_count <= '0;
      bit_index  <= '0;
    end else if (tx_accept) begin
      // load start bit low, lsb first, stop bit high
      shift_q    <= {1'b1, tx_byte, 1'b0};
      tx_busy    <= 1'b1;
      baud_count <= '0;
      bit_index  <= '0;
    end else if (tx_busy) begin
      if (bit_end) begin
        baud_count <= '0;
        shift_q    <= {1'b1, shift_q[9:1]};
        // index 9 is the stop bit
        if (bit_index == 4'd9) begin
          tx_busy <= 1'b0;
        end else begin
          bit_index <= bit_index + 1'b1;
        end
      end else begin
        baud_count <= baud_count + 1'b1;
      end
    end
  end

  // idle line must be a mark
  a_idle_high: assert property (@(posedge clk) disable iff (uart_reset)
    !tx_busy |-> txd);

endmodule
